/* design/perf_config.svh */
`ifndef PERF_CONFIG_SVH
`define PERF_CONFIG_SVH

// --------------------------------------------------
// AXI write master
// --------------------------------------------------
`define PERF_ADDR_W 20
`define PERF_DATA_W 16
`define PERF_STRB_W (`PERF_DATA_W / 8)
// top bit of the bus ID names the generator
`define PERF_ID_W 4

// --------------------------------------------------
// exerciser
// --------------------------------------------------
// fixed by the register map
`define PERF_NUM_M 2
`define PERF_STAT_W 32
`define PERF_REG_W 32
`define PERF_REG_ADDR_W 4
`define PERF_CLOCK_FREQ 100_000_000

`endif

/* design/perf_pkg.sv */
`include "perf_config.svh"

package perf_pkg;

  typedef struct packed {
    logic [`PERF_ADDR_W-1:0] addr;
    logic [`PERF_ID_W-1:0]   id;
    logic [7:0]              len;
    logic [2:0]              size;
    logic [1:0]              burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`PERF_DATA_W-1:0] data;
    logic [`PERF_STRB_W-1:0] strb;
    logic                    last;
  } axi_w_t;

  typedef struct packed {
    logic [`PERF_ID_W-1:0] id;
    logic [1:0]            resp;
  } axi_b_t;

  // generator side, one ID bit less than the bus
  typedef struct packed {
    logic [`PERF_ADDR_W-1:0] addr;
    logic [`PERF_ID_W-2:0]   id;
    logic [7:0]              len;
    logic [2:0]              size;
    logic [1:0]              burst;
  } gen_aw_t;

  typedef struct packed {
    logic [`PERF_ID_W-2:0] id;
    logic [1:0]            resp;
  } gen_b_t;

  typedef struct packed {
    logic [`PERF_ADDR_W-1:0] base_addr;
    logic [7:0]              beats;
    logic [`PERF_ADDR_W-1:0] stride;
    logic [15:0]             num;
  } burst_cfg_t;

  typedef struct packed {
    logic [`PERF_STAT_W-1:0] aw_count;
    logic [`PERF_STAT_W-1:0] w_count;
    logic [`PERF_STAT_W-1:0] b_count;
    logic [`PERF_STAT_W-1:0] busy_cycles;
  } perf_stats_t;

  typedef enum logic {
    CTRL_IDLE,
    CTRL_RUNNING
  } ctrl_state_e;

  typedef enum logic [`PERF_REG_ADDR_W-1:0] {
    REG_START       = 4'd0,
    REG_IDLE        = 4'd1,
    REG_CLEAR       = 4'd2,
    REG_AW_COUNT    = 4'd3,
    REG_W_COUNT     = 4'd4,
    REG_B_COUNT     = 4'd5,
    REG_BUSY_CYCLES = 4'd6,
    REG_DATA_WIDTH  = 4'd7,
    REG_G0_BASE     = 4'd8,
    REG_G0_BEATS    = 4'd9,
    REG_G0_STRIDE   = 4'd10,
    REG_G0_NUM      = 4'd11,
    REG_G1_BASE     = 4'd12,
    REG_G1_BEATS    = 4'd13,
    REG_G1_STRIDE   = 4'd14,
    REG_G1_NUM      = 4'd15
  } reg_id_e;

endpackage

/* design/perf_regs.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_regs (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   reg_we,
  input  logic [`PERF_REG_ADDR_W-1:0]            reg_addr,
  input  logic [`PERF_REG_W-1:0]                 reg_wdata,
  output logic [`PERF_REG_W-1:0]                 reg_rdata,
  input  logic [`PERF_NUM_M-1:0]                 busy,
  input  perf_pkg::perf_stats_t                  stats,
  output logic [`PERF_NUM_M-1:0]                 start,
  output logic                                   clear,
  output logic                                   running,
  output perf_pkg::burst_cfg_t [`PERF_NUM_M-1:0] cfg
);

  perf_pkg::ctrl_state_e state;
  perf_pkg::reg_id_e     reg_id;
  // generator select, one bit for two generators
  logic                  cfg_sel;

  assign reg_id  = perf_pkg::reg_id_e'(reg_addr);
  assign cfg_sel = reg_addr[2];
  assign running = (state == perf_pkg::CTRL_RUNNING);

  // --------------------------------------------------
  // start/idle sequencing
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= perf_pkg::CTRL_IDLE;
      start <= '0;
      clear <= 1'b0;
    end else begin
      start <= '0;
      clear <= 1'b0;
      case (state)
        perf_pkg::CTRL_IDLE: begin
          if (|start) begin
            state <= perf_pkg::CTRL_RUNNING;
          end else if (reg_we && reg_id == perf_pkg::REG_START) begin
            start <= reg_wdata[`PERF_NUM_M-1:0];
          end
          if (reg_we && reg_id == perf_pkg::REG_CLEAR && reg_wdata[0]) begin
            clear <= 1'b1;
          end
        end
        perf_pkg::CTRL_RUNNING: begin
          // all generators done
          if (!(|busy)) begin
            state <= perf_pkg::CTRL_IDLE;
          end
        end
        default: state <= perf_pkg::CTRL_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // per generator burst config
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (reg_we) begin
      case (reg_id)
        perf_pkg::REG_G0_BASE, perf_pkg::REG_G1_BASE:
          cfg[cfg_sel].base_addr <= reg_wdata[`PERF_ADDR_W-1:0];
        perf_pkg::REG_G0_BEATS, perf_pkg::REG_G1_BEATS:
          cfg[cfg_sel].beats <= reg_wdata[7:0];
        perf_pkg::REG_G0_STRIDE, perf_pkg::REG_G1_STRIDE:
          cfg[cfg_sel].stride <= reg_wdata[`PERF_ADDR_W-1:0];
        perf_pkg::REG_G0_NUM, perf_pkg::REG_G1_NUM:
          cfg[cfg_sel].num <= reg_wdata[15:0];
        default: ;
      endcase
    end
  end

  // read mux, start and clear read back as 0
  always_comb begin
    reg_rdata = '0;
    case (reg_id)
      perf_pkg::REG_IDLE:        reg_rdata = `PERF_REG_W'(!running);
      perf_pkg::REG_AW_COUNT:    reg_rdata = `PERF_REG_W'(stats.aw_count);
      perf_pkg::REG_W_COUNT:     reg_rdata = `PERF_REG_W'(stats.w_count);
      perf_pkg::REG_B_COUNT:     reg_rdata = `PERF_REG_W'(stats.b_count);
      perf_pkg::REG_BUSY_CYCLES: reg_rdata = `PERF_REG_W'(stats.busy_cycles);
      perf_pkg::REG_DATA_WIDTH:  reg_rdata = `PERF_REG_W'(`PERF_DATA_W);
      perf_pkg::REG_G0_BASE, perf_pkg::REG_G1_BASE:
        reg_rdata = `PERF_REG_W'(cfg[cfg_sel].base_addr);
      perf_pkg::REG_G0_BEATS, perf_pkg::REG_G1_BEATS:
        reg_rdata = `PERF_REG_W'(cfg[cfg_sel].beats);
      perf_pkg::REG_G0_STRIDE, perf_pkg::REG_G1_STRIDE:
        reg_rdata = `PERF_REG_W'(cfg[cfg_sel].stride);
      perf_pkg::REG_G0_NUM, perf_pkg::REG_G1_NUM:
        reg_rdata = `PERF_REG_W'(cfg[cfg_sel].num);
      default: reg_rdata = '0;
    endcase
  end

endmodule

/* design/perf_wr_gen.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_wr_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  perf_pkg::burst_cfg_t cfg,
  output logic                 busy,
  output perf_pkg::gen_aw_t    aw,
  output logic                 aw_valid,
  input  logic                 aw_ready,
  output perf_pkg::axi_w_t     w,
  output logic                 w_valid,
  input  logic                 w_ready,
  input  perf_pkg::gen_b_t     b,
  input  logic                 b_valid,
  output logic                 b_ready
);

  localparam int SIZE = $clog2(`PERF_STRB_W);

  perf_pkg::burst_cfg_t    cfg_q;
  logic [15:0]             aw_cnt;
  logic [15:0]             w_cnt;
  logic [15:0]             b_cnt;
  logic [7:0]              beat_cnt;
  logic [`PERF_ADDR_W-1:0] aw_addr;
  logic [`PERF_ADDR_W-1:0] w_addr;
  logic [`PERF_ADDR_W-1:0] beat_addr;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    w_last;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign b_fire  = b_valid && b_ready;
  assign b_ready = 1'b1;

  // burst k at base + k * stride, id k mod 8
  assign aw_valid = busy && (aw_cnt != cfg_q.num);
  assign aw.addr  = aw_addr;
  assign aw.id    = aw_cnt[`PERF_ID_W-2:0];
  assign aw.len   = cfg_q.beats - 8'd1;
  assign aw.size  = 3'(SIZE);
  assign aw.burst = 2'b01;

  // W only for bursts whose AW went out
  assign w_last    = (beat_cnt == cfg_q.beats - 8'd1);
  assign beat_addr = w_addr + `PERF_ADDR_W'(beat_cnt);
  assign w_valid   = busy && (w_cnt != aw_cnt);
  assign w.data    = beat_addr[`PERF_DATA_W-1:0];
  assign w.strb    = '1;
  assign w.last    = w_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      aw_cnt   <= '0;
      w_cnt    <= '0;
      b_cnt    <= '0;
      beat_cnt <= '0;
    end else if (start && !busy) begin
      busy     <= 1'b1;
      aw_cnt   <= '0;
      w_cnt    <= '0;
      b_cnt    <= '0;
      beat_cnt <= '0;
    end else if (busy) begin
      if (aw_fire) begin
        aw_cnt <= aw_cnt + 16'd1;
      end
      if (w_fire) begin
        beat_cnt <= w_last ? 8'd0 : beat_cnt + 8'd1;
        if (w_last) begin
          w_cnt <= w_cnt + 16'd1;
        end
      end
      if (b_fire) begin
        b_cnt <= b_cnt + 16'd1;
      end
      // empty run ends after a single busy cycle
      if (cfg_q.num == '0 || (b_fire && b_cnt == cfg_q.num - 16'd1)) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      cfg_q   <= cfg;
      aw_addr <= cfg.base_addr;
      w_addr  <= cfg.base_addr;
    end else begin
      if (aw_fire) begin
        aw_addr <= aw_addr + cfg_q.stride;
      end
      if (w_fire && w_last) begin
        w_addr <= w_addr + cfg_q.stride;
      end
    end
  end

endmodule

/* design/perf_wr_arbiter.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_wr_arbiter (
  input  logic                                clk,
  input  logic                                rst_n,
  input  perf_pkg::gen_aw_t [`PERF_NUM_M-1:0] g_aw,
  input  logic [`PERF_NUM_M-1:0]              g_aw_valid,
  output logic [`PERF_NUM_M-1:0]              g_aw_ready,
  input  perf_pkg::axi_w_t [`PERF_NUM_M-1:0]  g_w,
  input  logic [`PERF_NUM_M-1:0]              g_w_valid,
  output logic [`PERF_NUM_M-1:0]              g_w_ready,
  output perf_pkg::gen_b_t [`PERF_NUM_M-1:0]  g_b,
  output logic [`PERF_NUM_M-1:0]              g_b_valid,
  input  logic [`PERF_NUM_M-1:0]              g_b_ready,
  output perf_pkg::axi_aw_t                   m_aw,
  output logic                                aw_valid,
  input  logic                                aw_ready,
  output perf_pkg::axi_w_t                    m_w,
  output logic                                w_valid,
  input  logic                                w_ready,
  input  perf_pkg::axi_b_t                    m_b,
  input  logic                                b_valid,
  output logic                                b_ready
);

  localparam int SEL_W = $clog2(`PERF_NUM_M);

  logic [SEL_W-1:0] rr_last;
  logic [SEL_W-1:0] rr_pick;
  logic [SEL_W-1:0] aw_sel;
  logic [SEL_W-1:0] aw_lock_sel;
  logic [SEL_W-1:0] w_owner;
  logic [SEL_W-1:0] b_sel;
  logic             aw_lock;
  logic             w_active;

  // round robin, starting after the last grant
  always_comb begin : rr_search
    logic [SEL_W-1:0] idx;
    logic             found;
    rr_pick = rr_last;
    found   = 1'b0;
    for (int k = 1; k <= `PERF_NUM_M; k++) begin
      idx = SEL_W'((int'(rr_last) + k) % `PERF_NUM_M);
      if (!found && g_aw_valid[idx]) begin
        rr_pick = idx;
        found   = 1'b1;
      end
    end
  end

  // a stalled AW keeps its grant so the payload holds
  assign aw_sel   = aw_lock ? aw_lock_sel : rr_pick;
  assign aw_valid = !w_active && g_aw_valid[aw_sel];
  assign m_aw     = '{addr:  g_aw[aw_sel].addr,
                      id:    {aw_sel, g_aw[aw_sel].id},
                      len:   g_aw[aw_sel].len,
                      size:  g_aw[aw_sel].size,
                      burst: g_aw[aw_sel].burst};

  assign m_w     = g_w[w_owner];
  assign w_valid = w_active && g_w_valid[w_owner];

  assign b_sel   = m_b.id[`PERF_ID_W-1 -: SEL_W];
  assign b_ready = g_b_ready[b_sel];

  always_comb begin
    for (int i = 0; i < `PERF_NUM_M; i++) begin
      g_aw_ready[i] = aw_ready && !w_active && (aw_sel == SEL_W'(i));
      g_w_ready[i]  = w_ready && w_active && (w_owner == SEL_W'(i));
      g_b[i].id     = m_b.id[`PERF_ID_W-2:0];
      g_b[i].resp   = m_b.resp;
      g_b_valid[i]  = b_valid && (b_sel == SEL_W'(i));
    end
  end

  // W locked to the AW winner until its last beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_last     <= '0;
      aw_lock     <= 1'b0;
      aw_lock_sel <= '0;
      w_active    <= 1'b0;
      w_owner     <= '0;
    end else begin
      aw_lock     <= aw_valid && !aw_ready;
      aw_lock_sel <= aw_sel;
      if (aw_valid && aw_ready) begin
        rr_last  <= aw_sel;
        w_active <= 1'b1;
        w_owner  <= aw_sel;
      end else if (w_valid && w_ready && m_w.last) begin
        w_active <= 1'b0;
      end
    end
  end

endmodule

/* design/perf_wr_stats.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_wr_stats (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic                  running,
  input  logic                  aw_valid,
  input  logic                  aw_ready,
  input  logic                  w_valid,
  input  logic                  w_ready,
  input  logic                  b_valid,
  input  logic                  b_ready,
  output perf_pkg::perf_stats_t stats
);

  logic aw_fire;
  logic w_fire;
  logic b_fire;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;
  assign b_fire  = b_valid && b_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (clear) begin
      stats <= '0;
    end else begin
      if (aw_fire) begin
        stats.aw_count <= stats.aw_count + 1'b1;
      end
      if (w_fire) begin
        stats.w_count <= stats.w_count + 1'b1;
      end
      if (b_fire) begin
        stats.b_count <= stats.b_count + 1'b1;
      end
      // whole run, idle bus cycles included
      if (running) begin
        stats.busy_cycles <= stats.busy_cycles + 1'b1;
      end
    end
  end

endmodule

/* design/perf_top.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        reg_we,
  input  logic [`PERF_REG_ADDR_W-1:0] reg_addr,
  input  logic [`PERF_REG_W-1:0]      reg_wdata,
  output logic [`PERF_REG_W-1:0]      reg_rdata,
  output perf_pkg::axi_aw_t           m_aw,
  output logic                        aw_valid,
  input  logic                        aw_ready,
  output perf_pkg::axi_w_t            m_w,
  output logic                        w_valid,
  input  logic                        w_ready,
  input  perf_pkg::axi_b_t            m_b,
  input  logic                        b_valid,
  output logic                        b_ready
);

  logic [`PERF_NUM_M-1:0]                 start;
  logic [`PERF_NUM_M-1:0]                 busy;
  logic                                   clear;
  logic                                   running;
  perf_pkg::burst_cfg_t [`PERF_NUM_M-1:0] cfg;
  perf_pkg::perf_stats_t                  stats;

  // generator side of the arbiter
  perf_pkg::gen_aw_t [`PERF_NUM_M-1:0] g_aw;
  logic [`PERF_NUM_M-1:0]              g_aw_valid;
  logic [`PERF_NUM_M-1:0]              g_aw_ready;
  perf_pkg::axi_w_t [`PERF_NUM_M-1:0]  g_w;
  logic [`PERF_NUM_M-1:0]              g_w_valid;
  logic [`PERF_NUM_M-1:0]              g_w_ready;
  perf_pkg::gen_b_t [`PERF_NUM_M-1:0]  g_b;
  logic [`PERF_NUM_M-1:0]              g_b_valid;
  logic [`PERF_NUM_M-1:0]              g_b_ready;

  perf_regs u_regs (
    .clk, .rst_n,
    .reg_we, .reg_addr, .reg_wdata, .reg_rdata,
    .busy, .stats, .start, .clear, .running, .cfg
  );

  for (genvar i = 0; i < `PERF_NUM_M; i++) begin : gen_wr
    perf_wr_gen u_gen (
      .clk, .rst_n,
      .start(start[i]), .cfg(cfg[i]), .busy(busy[i]),
      .aw(g_aw[i]), .aw_valid(g_aw_valid[i]), .aw_ready(g_aw_ready[i]),
      .w(g_w[i]), .w_valid(g_w_valid[i]), .w_ready(g_w_ready[i]),
      .b(g_b[i]), .b_valid(g_b_valid[i]), .b_ready(g_b_ready[i])
    );
  end

  perf_wr_arbiter u_arb (
    .clk, .rst_n,
    .g_aw, .g_aw_valid, .g_aw_ready,
    .g_w, .g_w_valid, .g_w_ready,
    .g_b, .g_b_valid, .g_b_ready,
    .m_aw, .aw_valid, .aw_ready,
    .m_w, .w_valid, .w_ready,
    .m_b, .b_valid, .b_ready
  );

  // watches the shared bus
  perf_wr_stats u_stats (
    .clk, .rst_n, .clear, .running,
    .aw_valid, .aw_ready, .w_valid, .w_ready, .b_valid, .b_ready,
    .stats
  );

endmodule

/* bench/perf_asserts.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_asserts (
  input logic                   clk,
  input logic                   rst_n,
  input perf_pkg::axi_aw_t      m_aw,
  input logic                   aw_valid,
  input logic                   aw_ready,
  input perf_pkg::axi_w_t       m_w,
  input logic                   w_valid,
  input logic                   w_ready,
  input logic [`PERF_NUM_M-1:0] start,
  input logic                   running
);

  logic [7:0] burst_len;
  logic [7:0] beat_idx;

  // W bursts follow the AW order one at a time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      burst_len <= '0;
      beat_idx  <= '0;
    end else begin
      if (aw_valid && aw_ready) begin
        burst_len <= m_aw.len;
      end
      if (w_valid && w_ready) begin
        beat_idx <= m_w.last ? 8'd0 : beat_idx + 8'd1;
      end
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(m_aw))
    else $error("AW dropped or changed before aw_ready");

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(m_w))
    else $error("W dropped or changed before w_ready");

  wlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && w_ready |-> (m_w.last == (beat_idx == burst_len)))
    else $error("wlast not on the beat given by awlen");

  no_start_running: assert property (@(posedge clk) disable iff (!rst_n)
    running |-> start == '0)
    else $error("start pulse while running");

endmodule

bind perf_top perf_asserts u_asserts (
  .clk, .rst_n,
  .m_aw, .aw_valid, .aw_ready,
  .m_w, .w_valid, .w_ready,
  .start, .running
);

/* bench/perf_tb.sv */
`timescale 1ns/1ps
`include "perf_config.svh"

module perf_tb;

  localparam int WAIT_LIMIT = 4000;

  typedef struct packed {
    logic                    gen;
    logic [`PERF_ADDR_W-1:0] addr;
    logic [`PERF_DATA_W-1:0] data;
    logic                    last;
  } beat_t;

  logic                        clk;
  logic                        rst_n;
  logic                        reg_we;
  logic [`PERF_REG_ADDR_W-1:0] reg_addr;
  logic [`PERF_REG_W-1:0]      reg_wdata;
  logic [`PERF_REG_W-1:0]      reg_rdata;
  perf_pkg::axi_aw_t           m_aw;
  logic                        aw_valid;
  logic                        aw_ready;
  perf_pkg::axi_w_t            m_w;
  logic                        w_valid;
  logic                        w_ready;
  perf_pkg::axi_b_t            m_b;
  logic                        b_valid;
  logic                        b_ready;

  integer seed = 37112;
  string  cur_test;
  int     test_errors;
  int     total_errors;
  int     tests_run;
  int     tests_failed;
  logic [31:0] busy_val;

  // slave model state
  perf_pkg::axi_aw_t     aw_q[$];
  logic [`PERF_ID_W-1:0] b_id_q[$];
  int                    b_due_q[$];
  logic [7:0]            w_beat;
  logic                  b_done;
  int                    cyc;
  int                    aw_seen[`PERF_NUM_M];
  beat_t                 log_q[$];
  beat_t                 exp_q[`PERF_NUM_M][$];

  perf_top UUT (.*);

  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // burst k at base + k * stride, beat j one address up, data is the low address bits
  function automatic beat_t expected_beat(input perf_pkg::burst_cfg_t cfg, input logic gen,
                                          input int k, input int j);
    beat_t b;
    b.gen  = gen;
    b.addr = `PERF_ADDR_W'(cfg.base_addr + k * cfg.stride + j);
    b.data = b.addr[`PERF_DATA_W-1:0];
    b.last = (j == cfg.beats - 1);
    expected_beat = b;
  endfunction

  task automatic check(input string what, input logic [63:0] expected, input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  // --------------------------------------------------
  // AXI slave model
  // --------------------------------------------------
  always begin
    @(negedge clk);
    if (rst_n) begin
      if (aw_valid && aw_ready) begin
        aw_q.push_back(m_aw);
        // size from the bus width in bytes, burst INCR and id k mod 8
        check("aw size", $clog2(`PERF_STRB_W), m_aw.size);
        check("aw burst", 2'b01, m_aw.burst);
        check("aw id", aw_seen[m_aw.id[`PERF_ID_W-1]] % 8, m_aw.id[`PERF_ID_W-2:0]);
        aw_seen[m_aw.id[`PERF_ID_W-1]]++;
      end
      if (w_valid && w_ready) begin
        if (aw_q.size() == 0) begin
          $display("%s: W beat accepted without an open AW burst", cur_test);
          test_errors++;
          total_errors++;
        end else begin
          log_q.push_back('{gen: aw_q[0].id[`PERF_ID_W-1], addr: aw_q[0].addr + w_beat,
                            data: m_w.data, last: m_w.last});
          if (w_beat == aw_q[0].len) begin
            b_id_q.push_back(aw_q[0].id);
            b_due_q.push_back(cyc + rand_below(4));
            void'(aw_q.pop_front());
            w_beat = '0;
          end else begin
            w_beat++;
          end
        end
      end
      if (b_valid && b_ready) begin
        b_done = 1'b1;
      end
    end
    @(posedge clk);
    #2;
    cyc++;
    aw_ready = (rand_below(100) < 70);
    w_ready  = (rand_below(100) < 70);
    if (b_done) begin
      b_valid = 1'b0;
      b_done  = 1'b0;
    end
    if (!b_valid && b_id_q.size() > 0 && cyc >= b_due_q[0]) begin
      m_b.id   = b_id_q.pop_front();
      m_b.resp = 2'b00;
      void'(b_due_q.pop_front());
      b_valid  = 1'b1;
    end
  end

  // logged beats against the reference order per generator
  always @(posedge clk) begin : compare_beats
    beat_t got;
    beat_t want;
    while (log_q.size() > 0) begin
      got = log_q.pop_front();
      if (exp_q[got.gen].size() == 0) begin
        $display("%s: extra W beat from generator %0d at 0x%0h", cur_test, got.gen, got.addr);
        test_errors++;
        total_errors++;
      end else begin
        want = exp_q[got.gen].pop_front();
        check("beat address", want.addr, got.addr);
        check("beat data", want.data, got.data);
        check("beat last", want.last, got.last);
      end
    end
  end

  // --------------------------------------------------
  // register port
  // --------------------------------------------------
  task automatic reg_write(input logic [`PERF_REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #2;
    reg_we = 1'b0;
  endtask

  task automatic reg_read(input logic [`PERF_REG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    reg_addr = addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic expect_reg(input string what, input logic [`PERF_REG_ADDR_W-1:0] addr,
                            input logic [31:0] expected);
    logic [31:0] v;
    reg_read(addr, v);
    check(what, expected, v);
  endtask

  // writes the four config registers and queues the reference beats
  task automatic setup_gen(input logic gen, input perf_pkg::burst_cfg_t cfg);
    logic [`PERF_REG_ADDR_W-1:0] base;
    base = `PERF_REG_ADDR_W'(perf_pkg::REG_G0_BASE + 4 * gen);
    aw_seen[gen] = 0;
    reg_write(base, 32'(cfg.base_addr));
    reg_write(base + 1, 32'(cfg.beats));
    reg_write(base + 2, 32'(cfg.stride));
    reg_write(base + 3, 32'(cfg.num));
    for (int k = 0; k < cfg.num; k++) begin
      for (int j = 0; j < cfg.beats; j++) begin
        exp_q[gen].push_back(expected_beat(cfg, gen, k, j));
      end
    end
  endtask

  task automatic wait_run_done();
    logic [31:0] idle;
    int          n;
    idle = '0;
    n    = 0;
    while (!(idle == 1 && b_id_q.size() == 0 && !b_valid) && n < WAIT_LIMIT) begin
      reg_read(perf_pkg::REG_IDLE, idle);
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      $display("%s: timed out waiting for idle and the last B response", cur_test);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    @(posedge clk);
    #1;
    for (int g = 0; g < `PERF_NUM_M; g++) begin
      if (exp_q[g].size() != 0) begin
        $display("%s: %0d beats of generator %0d never arrived", cur_test, exp_q[g].size(), g);
        test_errors++;
        total_errors++;
        exp_q[g].delete();
      end
    end
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %s (%0d errors)", cur_test, test_errors == 0 ? "ok" : "fail", test_errors);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    aw_ready     = 1'b0;
    w_ready      = 1'b0;
    m_b          = '0;
    b_valid      = 1'b0;
    b_done       = 1'b0;
    w_beat       = '0;
    cyc          = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    begin_test("reset");
    expect_reg("idle", perf_pkg::REG_IDLE, 1);
    expect_reg("data width", perf_pkg::REG_DATA_WIDTH, 16);
    expect_reg("aw count", perf_pkg::REG_AW_COUNT, 0);
    expect_reg("w count", perf_pkg::REG_W_COUNT, 0);
    expect_reg("b count", perf_pkg::REG_B_COUNT, 0);
    expect_reg("busy cycles", perf_pkg::REG_BUSY_CYCLES, 0);
    repeat (10) begin
      @(negedge clk);
      check("aw_valid", 0, aw_valid);
      check("w_valid", 0, w_valid);
    end
    end_test();

    begin_test("single_gen");
    setup_gen(0, '{base_addr: 20'h01000, beats: 8'd4, stride: 20'h00040, num: 16'd3});
    reg_write(perf_pkg::REG_START, 32'h1);
    wait_run_done();
    end_test();

    begin_test("both_gens");
    setup_gen(0, '{base_addr: 20'h20000, beats: 8'd3, stride: 20'h00010, num: 16'd5});
    setup_gen(1, '{base_addr: 20'hfff00, beats: 8'd6, stride: 20'h00080, num: 16'd9});
    reg_write(perf_pkg::REG_START, 32'h3);
    wait_run_done();
    end_test();

    // totals over the two runs above
    begin_test("counters");
    expect_reg("aw count", perf_pkg::REG_AW_COUNT, 17);
    expect_reg("w count", perf_pkg::REG_W_COUNT, 81);
    expect_reg("b count", perf_pkg::REG_B_COUNT, 17);
    reg_read(perf_pkg::REG_BUSY_CYCLES, busy_val);
    check("busy cycles nonzero", 1, busy_val != 0);
    end_test();

    begin_test("clear_restart");
    reg_write(perf_pkg::REG_CLEAR, 32'h1);
    expect_reg("aw count", perf_pkg::REG_AW_COUNT, 0);
    expect_reg("w count", perf_pkg::REG_W_COUNT, 0);
    expect_reg("b count", perf_pkg::REG_B_COUNT, 0);
    expect_reg("busy cycles", perf_pkg::REG_BUSY_CYCLES, 0);
    setup_gen(0, '{base_addr: 20'h30000, beats: 8'd2, stride: 20'h00008, num: 16'd4});
    reg_write(perf_pkg::REG_START, 32'h1);
    // ignored, generator 1 must stay silent
    reg_write(perf_pkg::REG_START, 32'h3);
    wait_run_done();
    expect_reg("aw count", perf_pkg::REG_AW_COUNT, 4);
    expect_reg("w count", perf_pkg::REG_W_COUNT, 8);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/perf_pkg.sv
design/perf_regs.sv
design/perf_wr_gen.sv
design/perf_wr_arbiter.sv
design/perf_wr_stats.sv
design/perf_top.sv
bench/perf_asserts.sv
bench/perf_tb.sv

/* Bender.yml */
package:
  name: perf_exerciser

sources:
  - include_dirs:
      - design
    files:
      - design/perf_pkg.sv
      - design/perf_regs.sv
      - design/perf_wr_gen.sv
      - design/perf_wr_arbiter.sv
      - design/perf_wr_stats.sv
      - design/perf_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/perf_asserts.sv
      - bench/perf_tb.sv
